// File: sa_ctrl_pkg.sv
package sa_ctrl_pkg;

    //////////////////////////////
    // Array and field sizes
    //////////////////////////////
    localparam int N_ROWS     = 4;
    localparam int N_COLS     = 4;
    localparam int MAX_FILTER = 3;
    localparam int SEL_W      = 2;
    localparam int NCOL_W     = 2;
    localparam int TR_W       = 2;
    localparam int CFG_W      = N_ROWS * (SEL_W + NCOL_W + TR_W + 1);

    // Bit offsets of the field groups in the ROM word
    localparam int SEL_OFS  = 0;
    localparam int NCOL_OFS = SEL_OFS + N_ROWS * SEL_W;
    localparam int TR_OFS   = NCOL_OFS + N_ROWS * NCOL_W;
    localparam int EN_OFS   = TR_OFS + N_ROWS * TR_W;

    localparam int ROM_ADDR_W  = 10;
    localparam int FEAT_ADDR_W = 16;
    localparam int CH_W        = 6;
    localparam int ITER_W      = 4;
    localparam int IN_RND_W    = 5;

    //////////////////////////////
    // Phase timing
    //////////////////////////////
    localparam int READY_CYCLES = 3;
    localparam int DRAIN_BASE   = 6;
    localparam int DRAIN_MAX    = 2 * (MAX_FILTER - 1) + DRAIN_BASE;
    localparam int LOAD_CNT_W   = $clog2(N_COLS);
    localparam int READY_CNT_W  = $clog2(READY_CYCLES);
    localparam int DRAIN_W      = $clog2(DRAIN_MAX + 1);

    // Phase encoding
    localparam int PH_W = 4;
    localparam logic [PH_W-1:0] PH_IDLE         = 4'd0;
    localparam logic [PH_W-1:0] PH_WAIT_WEIGHT  = 4'd1;
    localparam logic [PH_W-1:0] PH_LOAD         = 4'd2;
    localparam logic [PH_W-1:0] PH_WAIT_BRAM    = 4'd3;
    localparam logic [PH_W-1:0] PH_READY        = 4'd4;
    localparam logic [PH_W-1:0] PH_START        = 4'd5;
    localparam logic [PH_W-1:0] PH_WAITING      = 4'd6;
    localparam logic [PH_W-1:0] PH_STORE        = 4'd7;
    localparam logic [PH_W-1:0] PH_NEXT_CHANNEL = 4'd8;
    localparam logic [PH_W-1:0] PH_NEXT_FILTER  = 4'd9;
    localparam logic [PH_W-1:0] PH_NEXT_INPUT   = 4'd10;

endpackage

// File: sa_step_if.sv
`timescale 1ns/100ps

interface sa_step_if;
    import sa_ctrl_pkg::*;

    // Strobes from the sequencer
    logic [PH_W-1:0] phase;
    logic            clear;
    logic            cfg_load;
    logic            feat_step;
    logic            input_step;
    logic            drain_enter;
    logic            store_step;
    logic            next_input_step;

    // Loop status back to the sequencer
    logic               chans_done;
    logic               filters_done;
    logic               inputs_done;
    logic               input_last;
    logic [DRAIN_W-1:0] drain_len;
    logic [NCOL_W-1:0]  filter_size;

    modport seq (
        output phase, clear, cfg_load, feat_step, input_step, drain_enter,
               store_step, next_input_step,
        input  chans_done, filters_done, inputs_done, input_last, drain_len
    );

    modport cfg (input clear, cfg_load);

    modport loop (
        input  phase, clear, cfg_load, feat_step, input_step, drain_enter,
               store_step, next_input_step,
        output chans_done, filters_done, inputs_done, input_last, drain_len, filter_size
    );

endinterface

// File: sa_phase_fsm.sv
`timescale 1ns/100ps

module sa_phase_fsm (
    input  logic   clk_i,
    input  logic   sel_mux_tr_rst,
    input  logic   input_ready_i,
    input  logic   weight_ready_i,
    input  logic   bram_ready_i,
    sa_step_if.seq step,
    output logic   rst_o,
    output logic   load_o,
    output logic   ready_o,
    output logic   start_op_o,
    output logic   rd_weight_ld_o,
    output logic   rd_weight_rst_o,
    output logic   rd_feature_ld_o,
    output logic   rd_rom_signals_ld_o
);
    import sa_ctrl_pkg::*;

    logic [PH_W-1:0]        ph_q;
    logic [PH_W-1:0]        ph_nxt;
    logic [LOAD_CNT_W-1:0]  load_cnt_q;
    logic [READY_CNT_W-1:0] ready_cnt_q;
    logic [DRAIN_W-1:0]     drain_cnt_q;
    logic                   drain_last;

    assign drain_last = (drain_cnt_q == step.drain_len - 1'b1);

    //////////////////////////////
    // Next phase
    //////////////////////////////
    always_comb begin
        ph_nxt = ph_q;
        case (ph_q)
            // Every new pass starts the same way
            PH_IDLE, PH_NEXT_CHANNEL, PH_NEXT_FILTER, PH_NEXT_INPUT: begin
                if (input_ready_i) begin
                    ph_nxt = weight_ready_i ? PH_LOAD : PH_WAIT_WEIGHT;
                end
            end
            PH_WAIT_WEIGHT: begin
                if (weight_ready_i) ph_nxt = PH_LOAD;
            end
            PH_LOAD: begin
                if (load_cnt_q == LOAD_CNT_W'(N_COLS - 1)) ph_nxt = PH_WAIT_BRAM;
            end
            PH_WAIT_BRAM: begin
                if (bram_ready_i) ph_nxt = PH_READY;
            end
            PH_READY: begin
                if (ready_cnt_q == READY_CNT_W'(READY_CYCLES - 1)) ph_nxt = PH_START;
            end
            PH_START: begin
                // Last input sent and nothing pending upstream
                if (step.input_last && !input_ready_i && !bram_ready_i) begin
                    ph_nxt = PH_WAITING;
                end
            end
            PH_WAITING: begin
                if (drain_last) begin
                    ph_nxt = step.chans_done ? PH_STORE : PH_NEXT_CHANNEL;
                end
            end
            PH_STORE: begin
                if (step.filters_done && step.inputs_done) ph_nxt = PH_IDLE;
                else if (step.filters_done) ph_nxt = PH_NEXT_INPUT;
                else ph_nxt = PH_NEXT_FILTER;
            end
            default: ph_nxt = PH_IDLE;
        endcase
    end

    // Phase register and timers; each timer sits at zero outside its phase
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            ph_q        <= PH_IDLE;
            load_cnt_q  <= '0;
            ready_cnt_q <= '0;
            drain_cnt_q <= '0;
        end else begin
            ph_q        <= ph_nxt;
            load_cnt_q  <= (ph_q == PH_LOAD) ? load_cnt_q + 1'b1 : '0;
            ready_cnt_q <= (ph_q == PH_READY) ? ready_cnt_q + 1'b1 : '0;
            drain_cnt_q <= (ph_q == PH_WAITING) ? drain_cnt_q + 1'b1 : '0;
        end
    end

    //////////////////////////////
    // Strobes to the datapath
    //////////////////////////////
    assign step.phase           = ph_q;
    assign step.clear           = (ph_q == PH_IDLE);
    assign step.cfg_load        = (ph_q == PH_LOAD);
    assign step.feat_step       = (ph_q == PH_READY) || (ph_q == PH_START);
    assign step.input_step      = (ph_q == PH_START);
    assign step.drain_enter     = (ph_q == PH_WAITING) && (drain_cnt_q == '0);
    assign step.store_step      = (ph_q == PH_STORE);
    assign step.next_input_step = (ph_q == PH_STORE) && step.filters_done && !step.inputs_done;

    // Array control outputs
    assign rst_o               = (ph_q == PH_IDLE);
    assign rd_weight_rst_o     = (ph_q == PH_IDLE);
    assign load_o              = (ph_q == PH_LOAD);
    assign rd_weight_ld_o      = (ph_q == PH_LOAD);
    assign rd_rom_signals_ld_o = (ph_q == PH_LOAD);
    assign ready_o             = (ph_q == PH_READY);
    assign rd_feature_ld_o     = step.feat_step;
    assign start_op_o          = (ph_q == PH_START) || (ph_q == PH_WAITING);

endmodule

// File: sa_config_regs.sv
`timescale 1ns/100ps

module sa_config_regs (
    input  logic                                                   clk_i,
    input  logic                                                   sel_mux_tr_rst,
    input  logic [sa_ctrl_pkg::CFG_W-1:0]                          rom_word_i,
    sa_step_if.cfg                                                 step,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::SEL_W-1:0]  f_sel_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NCOL_W-1:0] number_of_columns_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NCOL_W-1:0] column_num_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::TR_W-1:0]   sel_mux_tr_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0]                          en_adder_node_o
);
    import sa_ctrl_pkg::*;

    logic [N_ROWS-1:0][SEL_W-1:0]  f_sel_fld;
    logic [N_ROWS-1:0][NCOL_W-1:0] ncol_fld;
    logic [N_ROWS-1:0][TR_W-1:0]   tr_fld;
    logic [N_ROWS-1:0]             en_fld;
    logic [N_ROWS-1:0][TR_W-1:0]   tr_pre_q;
    logic [N_ROWS-1:0][NCOL_W-1:0] col_cnt_q;

    //////////////////////////////
    // ROM word decode
    //////////////////////////////
    // Groups packed back to back, row 0 in the low bits of each
    assign f_sel_fld = rom_word_i[SEL_OFS +: N_ROWS * SEL_W];
    assign ncol_fld  = rom_word_i[NCOL_OFS +: N_ROWS * NCOL_W];
    assign tr_fld    = rom_word_i[TR_OFS +: N_ROWS * TR_W];
    assign en_fld    = rom_word_i[EN_OFS +: N_ROWS];

    //////////////////////////////
    // Per-row registers
    //////////////////////////////
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            f_sel_o             <= '0;
            number_of_columns_o <= '0;
            column_num_o        <= '0;
            tr_pre_q            <= '0;
            sel_mux_tr_o        <= '0;
            en_adder_node_o     <= '0;
            col_cnt_q           <= '0;
        end else if (step.clear) begin
            f_sel_o             <= '0;
            number_of_columns_o <= '0;
            column_num_o        <= '0;
            tr_pre_q            <= '0;
            sel_mux_tr_o        <= '0;
            en_adder_node_o     <= '0;
            col_cnt_q           <= '0;
        end else if (step.cfg_load) begin
            f_sel_o             <= f_sel_fld;
            number_of_columns_o <= ncol_fld;
            en_adder_node_o     <= en_fld;
            // Transfer selects trail the rest by one load cycle
            tr_pre_q            <= tr_fld;
            sel_mux_tr_o        <= tr_pre_q;
            // Column number counts down from the row's column count
            for (int r = 0; r < N_ROWS; r++) begin
                column_num_o[r] <= ncol_fld[r] - col_cnt_q[r];
                if (col_cnt_q[r] == ncol_fld[r] - 1'b1) begin
                    col_cnt_q[r] <= '0;
                end else begin
                    col_cnt_q[r] <= col_cnt_q[r] + 1'b1;
                end
            end
        end
    end

endmodule

// File: sa_row_map.sv
`timescale 1ns/100ps

module sa_row_map (
    input  logic [sa_ctrl_pkg::NCOL_W-1:0]                          filter_size_i,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NCOL_W-1:0] row_num_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0]                          sel_mux_node_o
);
    import sa_ctrl_pkg::*;

    // Rows are grouped by filter size, numbering restarts at 1 per group
    always_comb begin
        logic [NCOL_W-1:0] pos;
        logic [NCOL_W-1:0] row;
        pos = '0;
        for (int i = 0; i < N_ROWS; i++) begin
            if (pos == filter_size_i) begin
                pos = '0;
            end
            row = pos + 1'b1;
            row_num_o[i] = row;
            // Last row of a group feeds the node adder directly
            sel_mux_node_o[i] = (row != filter_size_i);
            pos = pos + 1'b1;
        end
    end

endmodule

// File: sa_loop_counters.sv
`timescale 1ns/100ps

module sa_loop_counters (
    input  logic                                clk_i,
    input  logic                                sel_mux_tr_rst,
    input  logic [sa_ctrl_pkg::NCOL_W-1:0]      filter_size_i,
    input  logic [sa_ctrl_pkg::ITER_W-1:0]      iteration_num_filters_i,
    input  logic [sa_ctrl_pkg::ITER_W-1:0]      iteration_num_inputs_i,
    input  logic [sa_ctrl_pkg::CH_W-1:0]        total_num_channels_i,
    input  logic [sa_ctrl_pkg::IN_RND_W-1:0]    num_input_a_round_i,
    sa_step_if.loop                             step,
    output logic [sa_ctrl_pkg::FEAT_ADDR_W-1:0] in_feature_addr_o,
    output logic [sa_ctrl_pkg::ROM_ADDR_W-1:0]  rom_addr_o
);
    import sa_ctrl_pkg::*;

    logic [NCOL_W-1:0]   fs_q;
    logic [ITER_W-1:0]   iter_flt_q;
    logic [ITER_W-1:0]   iter_in_q;
    logic [CH_W-1:0]     total_ch_q;
    logic [IN_RND_W-1:0] num_in_q;
    logic [CH_W-1:0]     ch_cnt_q;
    logic [ITER_W-1:0]   flt_rnd_q;
    logic [ITER_W-1:0]   in_rnd_q;
    logic [IN_RND_W-1:0] in_cnt_q;
    logic [CH_W-1:0]     ch_per_pass;

    // Channels covered by one pass of the array
    assign ch_per_pass = (fs_q == '0) ? '0 : CH_W'(N_ROWS / fs_q);

    //////////////////////////////
    // Layer parameters
    //////////////////////////////
    // Tracks the inputs in idle, so the value on the exit edge is kept
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            fs_q       <= '0;
            iter_flt_q <= '0;
            iter_in_q  <= '0;
            total_ch_q <= '0;
            num_in_q   <= '0;
        end else if (step.clear) begin
            fs_q       <= filter_size_i;
            iter_flt_q <= iteration_num_filters_i;
            iter_in_q  <= iteration_num_inputs_i;
            total_ch_q <= total_num_channels_i;
            num_in_q   <= num_input_a_round_i;
        end
    end

    //////////////////////////////
    // Loop and address counters
    //////////////////////////////
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            ch_cnt_q          <= '0;
            flt_rnd_q         <= '0;
            in_rnd_q          <= '0;
            in_cnt_q          <= '0;
            in_feature_addr_o <= '0;
            rom_addr_o        <= '0;
        end else if (step.clear) begin
            ch_cnt_q          <= '0;
            flt_rnd_q         <= '0;
            in_rnd_q          <= '0;
            in_cnt_q          <= '0;
            in_feature_addr_o <= '0;
            rom_addr_o        <= '0;
        end else begin
            if (step.drain_enter) ch_cnt_q <= ch_cnt_q + ch_per_pass;
            else if (step.store_step) ch_cnt_q <= '0;
            // A new input round restarts the filter rounds
            if (step.next_input_step) begin
                flt_rnd_q <= '0;
                in_rnd_q  <= in_rnd_q + 1'b1;
            end else if (step.store_step) begin
                flt_rnd_q <= flt_rnd_q + 1'b1;
            end
            // Input count holds on the last input of the round
            if (step.input_step && !step.input_last) in_cnt_q <= in_cnt_q + 1'b1;
            else if (step.drain_enter) in_cnt_q <= '0;
            if (step.feat_step) in_feature_addr_o <= in_feature_addr_o + 1'b1;
            else if (step.phase == PH_WAITING) in_feature_addr_o <= '0;
            if (step.cfg_load) rom_addr_o <= rom_addr_o + 1'b1;
        end
    end

    // Status back to the sequencer
    assign step.chans_done   = (ch_cnt_q >= total_ch_q);
    assign step.filters_done = (flt_rnd_q == iter_flt_q);
    assign step.inputs_done  = (in_rnd_q == iter_in_q);
    assign step.input_last   = (in_cnt_q == num_in_q - 1'b1);
    assign step.drain_len    = DRAIN_W'(2 * fs_q + DRAIN_BASE - 2);
    assign step.filter_size  = fs_q;

endmodule

// File: sa_controller.sv
`timescale 1ns/100ps

module sa_controller (
    input  logic                                                    clk_i,
    input  logic                                                    sel_mux_tr_rst,
    input  logic                                                    input_ready_i,
    input  logic                                                    weight_ready_i,
    input  logic                                                    bram_ready_i,
    input  logic [sa_ctrl_pkg::CFG_W-1:0]                           rom_word_i,
    input  logic [sa_ctrl_pkg::NCOL_W-1:0]                          filter_size_i,
    input  logic [sa_ctrl_pkg::ITER_W-1:0]                          iteration_num_filters_i,
    input  logic [sa_ctrl_pkg::ITER_W-1:0]                          iteration_num_inputs_i,
    input  logic [sa_ctrl_pkg::CH_W-1:0]                            total_num_channels_i,
    input  logic [sa_ctrl_pkg::IN_RND_W-1:0]                        num_input_a_round_i,
    output logic                                                    rst_o,
    output logic                                                    load_o,
    output logic                                                    ready_o,
    output logic                                                    start_op_o,
    output logic                                                    rd_weight_ld_o,
    output logic                                                    rd_weight_rst_o,
    output logic                                                    rd_feature_ld_o,
    output logic                                                    rd_rom_signals_ld_o,
    output logic [sa_ctrl_pkg::FEAT_ADDR_W-1:0]                     in_feature_addr_o,
    output logic [sa_ctrl_pkg::ROM_ADDR_W-1:0]                      rom_addr_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::SEL_W-1:0]  f_sel_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NCOL_W-1:0] number_of_columns_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NCOL_W-1:0] column_num_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::TR_W-1:0]   sel_mux_tr_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0]                          en_adder_node_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NCOL_W-1:0] row_num_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0]                          sel_mux_node_o
);

    sa_step_if step_bus ();

    // Sequencer
    sa_phase_fsm u_phase_fsm (
        .clk_i               (clk_i),
        .sel_mux_tr_rst      (sel_mux_tr_rst),
        .input_ready_i       (input_ready_i),
        .weight_ready_i      (weight_ready_i),
        .bram_ready_i        (bram_ready_i),
        .step                (step_bus.seq),
        .rst_o               (rst_o),
        .load_o              (load_o),
        .ready_o             (ready_o),
        .start_op_o          (start_op_o),
        .rd_weight_ld_o      (rd_weight_ld_o),
        .rd_weight_rst_o     (rd_weight_rst_o),
        .rd_feature_ld_o     (rd_feature_ld_o),
        .rd_rom_signals_ld_o (rd_rom_signals_ld_o)
    );

    sa_config_regs u_config_regs (
        .clk_i               (clk_i),
        .sel_mux_tr_rst      (sel_mux_tr_rst),
        .rom_word_i          (rom_word_i),
        .step                (step_bus.cfg),
        .f_sel_o             (f_sel_o),
        .number_of_columns_o (number_of_columns_o),
        .column_num_o        (column_num_o),
        .sel_mux_tr_o        (sel_mux_tr_o),
        .en_adder_node_o     (en_adder_node_o)
    );

    // Row map follows the latched filter size
    sa_row_map u_row_map (
        .filter_size_i  (step_bus.filter_size),
        .row_num_o      (row_num_o),
        .sel_mux_node_o (sel_mux_node_o)
    );

    sa_loop_counters u_loop_counters (
        .clk_i                   (clk_i),
        .sel_mux_tr_rst          (sel_mux_tr_rst),
        .filter_size_i           (filter_size_i),
        .iteration_num_filters_i (iteration_num_filters_i),
        .iteration_num_inputs_i  (iteration_num_inputs_i),
        .total_num_channels_i    (total_num_channels_i),
        .num_input_a_round_i     (num_input_a_round_i),
        .step                    (step_bus.loop),
        .in_feature_addr_o       (in_feature_addr_o),
        .rom_addr_o              (rom_addr_o)
    );

endmodule

// File: sa_controller_chk.sv
`timescale 1ns/100ps

module sa_controller_chk (
    input logic                             clk_i,
    input logic                             sel_mux_tr_rst,
    input logic                             input_ready_i,
    input logic [sa_ctrl_pkg::NCOL_W-1:0]   filter_size_i,
    input logic                             rst_o,
    input logic                             load_o,
    input logic                             ready_o,
    input logic                             start_op_o,
    input logic                             rd_weight_ld_o,
    input logic                             rd_weight_rst_o,
    input logic                             rd_feature_ld_o,
    input logic                             rd_rom_signals_ld_o,
    input logic [sa_ctrl_pkg::FEAT_ADDR_W-1:0] in_feature_addr_o,
    input logic [sa_ctrl_pkg::ROM_ADDR_W-1:0]  rom_addr_o
);
    import sa_ctrl_pkg::*;

    int assert_fails = 0;
    int load_run;
    int ready_run;
    int drain_run;

    // Run lengths of the load, ready and drain phases
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            load_run  <= 0;
            ready_run <= 0;
            drain_run <= 0;
        end else begin
            load_run  <= load_o ? load_run + 1 : 0;
            ready_run <= ready_o ? ready_run + 1 : 0;
            // Drain is start_op_o without feature reads
            drain_run <= (start_op_o && !rd_feature_ld_o) ? drain_run + 1 : 0;
        end
    end

    //////////////////////////////
    // Idle
    //////////////////////////////
    idle_outputs: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        rst_o |-> rd_weight_rst_o && !load_o && !ready_o && !start_op_o &&
                  !rd_weight_ld_o && !rd_feature_ld_o && !rd_rom_signals_ld_o)
        else begin
            assert_fails++;
            $error("Control outputs active while the controller is idle");
        end

    idle_hold: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        rst_o && !input_ready_i |=> rst_o)
        else begin
            assert_fails++;
            $error("Controller left idle without input_ready_i");
        end

    //////////////////////////////
    // Phase lengths
    //////////////////////////////
    load_length: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        (load_o && load_run < N_COLS) || (!load_o && (load_run == 0 || load_run == N_COLS)))
        else begin
            assert_fails++;
            $error("Mismatch load_o burst length: got %0h expected %0h", load_run, N_COLS);
        end

    ready_length: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        (ready_o && ready_run < READY_CYCLES) ||
        (!ready_o && (ready_run == 0 || ready_run == READY_CYCLES)))
        else begin
            assert_fails++;
            $error("Mismatch ready_o length: got %0h expected %0h", ready_run, READY_CYCLES);
        end

    drain_length: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        !start_op_o && drain_run != 0 |-> drain_run == 2 * (int'(filter_size_i) - 1) + DRAIN_BASE)
        else begin
            assert_fails++;
            $error("Mismatch drain length: got %0h for filter size %0h", drain_run,
                   filter_size_i);
        end

    // Address counters
    rom_addr_step: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        load_o |=> rom_addr_o == $past(rom_addr_o) + 1'b1)
        else begin
            assert_fails++;
            $error("Mismatch rom_addr_o: got %0h after a load cycle", rom_addr_o);
        end

    feat_addr_step: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        rd_feature_ld_o |=> in_feature_addr_o == $past(in_feature_addr_o) + 1'b1)
        else begin
            assert_fails++;
            $error("Mismatch in_feature_addr_o: got %0h after a read", in_feature_addr_o);
        end

endmodule

// File: tb_sa_controller.sv
`timescale 1ns/100ps

module tb_sa_controller;
    import sa_ctrl_pkg::*;

    localparam int IDLE_TIMEOUT  = 200;
    localparam int LAYER_TIMEOUT = 20000;

    logic                              clk_i;
    logic                              sel_mux_tr_rst;
    logic                              input_ready_i;
    logic                              weight_ready_i;
    logic                              bram_ready_i;
    logic [CFG_W-1:0]                  rom_word_i;
    logic [NCOL_W-1:0]                 filter_size_i;
    logic [ITER_W-1:0]                 iteration_num_filters_i;
    logic [ITER_W-1:0]                 iteration_num_inputs_i;
    logic [CH_W-1:0]                   total_num_channels_i;
    logic [IN_RND_W-1:0]               num_input_a_round_i;
    logic                              rst_o;
    logic                              load_o;
    logic                              ready_o;
    logic                              start_op_o;
    logic                              rd_weight_ld_o;
    logic                              rd_weight_rst_o;
    logic                              rd_feature_ld_o;
    logic                              rd_rom_signals_ld_o;
    logic [FEAT_ADDR_W-1:0]            in_feature_addr_o;
    logic [ROM_ADDR_W-1:0]             rom_addr_o;
    logic [N_ROWS-1:0][SEL_W-1:0]      f_sel_o;
    logic [N_ROWS-1:0][NCOL_W-1:0]     number_of_columns_o;
    logic [N_ROWS-1:0][NCOL_W-1:0]     column_num_o;
    logic [N_ROWS-1:0][TR_W-1:0]       sel_mux_tr_o;
    logic [N_ROWS-1:0]                 en_adder_node_o;
    logic [N_ROWS-1:0][NCOL_W-1:0]     row_num_o;
    logic [N_ROWS-1:0]                 sel_mux_node_o;

    // Expected configuration after a load burst
    logic                              layer_go;
    logic                              cfg_pending;
    logic [N_ROWS-1:0][NCOL_W-1:0]     col_cnt_m;
    logic [N_ROWS-1:0][NCOL_W-1:0]     exp_col;
    logic [N_ROWS-1:0][SEL_W-1:0]      exp_fsel;
    logic [N_ROWS-1:0]                 exp_en;
    logic [N_ROWS-1:0][NCOL_W-1:0]     exp_ncol;
    logic [N_ROWS-1:0][TR_W-1:0]       exp_tr_pre;
    logic [N_ROWS-1:0][TR_W-1:0]       exp_tr;

    sa_controller UUT (.*);

    bind sa_controller sa_controller_chk u_chk (
        .clk_i             (clk_i),
        .sel_mux_tr_rst    (sel_mux_tr_rst),
        .input_ready_i     (input_ready_i),
        .filter_size_i     (filter_size_i),
        .rst_o             (rst_o),
        .load_o            (load_o),
        .ready_o           (ready_o),
        .start_op_o        (start_op_o),
        .rd_weight_ld_o    (rd_weight_ld_o),
        .rd_weight_rst_o   (rd_weight_rst_o),
        .rd_feature_ld_o   (rd_feature_ld_o),
        .rd_rom_signals_ld_o (rd_rom_signals_ld_o),
        .in_feature_addr_o (in_feature_addr_o),
        .rom_addr_o        (rom_addr_o)
    );

    always #4 clk_i = ~clk_i;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first failed check");
    endtask

    //////////////////////////////
    // Configuration model
    //////////////////////////////
    task automatic model_load(input logic [CFG_W-1:0] word);
        logic [NCOL_W-1:0] ncol;
        exp_fsel = word[SEL_OFS +: N_ROWS * SEL_W];
        exp_en   = word[EN_OFS +: N_ROWS];
        exp_ncol = word[NCOL_OFS +: N_ROWS * NCOL_W];
        // Transfer selects come out one load cycle late
        exp_tr     = exp_tr_pre;
        exp_tr_pre = word[TR_OFS +: N_ROWS * TR_W];
        for (int r = 0; r < N_ROWS; r++) begin
            ncol = word[NCOL_OFS + r * NCOL_W +: NCOL_W];
            exp_col[r] = ncol - col_cnt_m[r];
            // Counter restarts after reaching the column count minus one
            col_cnt_m[r] = (col_cnt_m[r] == ncol - 1'b1) ? '0 : col_cnt_m[r] + 1'b1;
        end
    endtask

    task automatic check_config();
        assert (f_sel_o == exp_fsel) else
            report_fail($sformatf("Mismatch f_sel_o: got %0h expected %0h", f_sel_o, exp_fsel));
        assert (en_adder_node_o == exp_en) else
            report_fail($sformatf("Mismatch en_adder_node_o: got %0h expected %0h",
                                  en_adder_node_o, exp_en));
        assert (column_num_o == exp_col) else
            report_fail($sformatf("Mismatch column_num_o: got %0h expected %0h",
                                  column_num_o, exp_col));
        assert (number_of_columns_o == exp_ncol) else
            report_fail($sformatf("Mismatch number_of_columns_o: got %0h expected %0h",
                                  number_of_columns_o, exp_ncol));
        assert (sel_mux_tr_o == exp_tr) else
            report_fail($sformatf("Mismatch sel_mux_tr_o: got %0h expected %0h",
                                  sel_mux_tr_o, exp_tr));
    endtask

    // One falling edge with checks and then new input levels
    task automatic drive_cycle();
        @(negedge clk_i);
        if (UUT.u_chk.assert_fails != 0) report_fail("A bound assertion on the DUT failed");
        if (cfg_pending && !load_o) begin
            check_config();
            cfg_pending = 1'b0;
        end
        if (load_o) cfg_pending = 1'b1;
        weight_ready_i = 1'($urandom % 2);
        bram_ready_i   = 1'($urandom % 2);
        input_ready_i  = (rst_o && !layer_go) ? 1'b0 : 1'($urandom % 2);
        rom_word_i     = CFG_W'($urandom);
        // Idle clears the registers on the next edge, a load cycle captures the word
        if (rst_o) begin
            col_cnt_m  = '0;
            exp_tr_pre = '0;
            exp_tr     = '0;
        end else if (load_o) begin
            model_load(rom_word_i);
        end
    endtask

    task automatic check_row_map(input int fs);
        logic [NCOL_W-1:0] exp_row;
        logic              exp_sel;
        for (int i = 0; i < N_ROWS; i++) begin
            exp_row = NCOL_W'((i % fs) + 1);
            // Zero only on the last row of each group
            exp_sel = ((i % fs) != fs - 1);
            assert (row_num_o[i] == exp_row) else
                report_fail($sformatf("Mismatch row_num_o[%0d]: got %0h expected %0h",
                                      i, row_num_o[i], exp_row));
            assert (sel_mux_node_o[i] == exp_sel) else
                report_fail($sformatf("Mismatch sel_mux_node_o[%0d]: got %0h expected %0h",
                                      i, sel_mux_node_o[i], exp_sel));
        end
    endtask

    //////////////////////////////
    // One full layer
    //////////////////////////////
    task automatic run_layer(input int fs, input int flt, input int inr, input int ch,
                             input int nin);
        int cycles;
        int bursts;
        int per_pass;
        int expected;
        logic load_seen;
        filter_size_i           = NCOL_W'(fs);
        iteration_num_filters_i = ITER_W'(flt);
        iteration_num_inputs_i  = ITER_W'(inr);
        total_num_channels_i    = CH_W'(ch);
        num_input_a_round_i     = IN_RND_W'(nin);
        layer_go = 1'b1;
        cycles = 0;
        while (rst_o) begin
            drive_cycle();
            cycles++;
            if (cycles > IDLE_TIMEOUT) report_fail("Controller did not leave idle");
        end
        layer_go = 1'b0;
        bursts = 0;
        load_seen = 1'b0;
        cycles = 0;
        while (!rst_o) begin
            if (load_o && !load_seen) bursts++;
            load_seen = load_o;
            drive_cycle();
            cycles++;
            if (cycles > LAYER_TIMEOUT) report_fail("Layer did not return to idle in time");
        end
        per_pass = N_ROWS / fs;
        expected = ((ch + per_pass - 1) / per_pass) * (flt + 1) * (inr + 1);
        assert (bursts == expected) else
            report_fail($sformatf("Mismatch load_o bursts: got %0h expected %0h",
                                  bursts, expected));
        check_row_map(fs);
    endtask

    initial begin
        void'($urandom(32'h0cccfc8b));
        clk_i                   = 1'b0;
        sel_mux_tr_rst          = 1'b1;
        input_ready_i           = 1'b0;
        weight_ready_i          = 1'b0;
        bram_ready_i            = 1'b0;
        rom_word_i              = '0;
        filter_size_i           = NCOL_W'(1);
        iteration_num_filters_i = '0;
        iteration_num_inputs_i  = '0;
        total_num_channels_i    = CH_W'(1);
        num_input_a_round_i     = IN_RND_W'(1);
        layer_go                = 1'b0;
        cfg_pending             = 1'b0;
        col_cnt_m               = '0;
        exp_col                 = '0;
        exp_fsel                = '0;
        exp_en                  = '0;
        exp_ncol                = '0;
        exp_tr_pre              = '0;
        exp_tr                  = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        sel_mux_tr_rst = 1'b0;

        // Idle holds while input_ready_i stays low
        repeat (4) drive_cycle();
        assert (rst_o && rd_weight_rst_o) else
            report_fail("Controller left idle without input_ready_i");

        for (int n = 0; n < 3; n++) begin
            run_layer(n + 1, int'($urandom % 2), int'($urandom % 2),
                      int'($urandom % 6) + 1, int'($urandom % 4) + 1);
        end
        repeat (2) drive_cycle();

        if (UUT.u_chk.assert_fails == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_fail("A bound assertion on the DUT failed");
        end
    end

endmodule

// File: src.f
sa_ctrl_pkg.sv
sa_step_if.sv
sa_phase_fsm.sv
sa_config_regs.sv
sa_row_map.sv
sa_loop_counters.sv
sa_controller.sv
sa_controller_chk.sv
tb_sa_controller.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the controller testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_sa_controller -o tb_sa_controller -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sa_controller +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -eq 0 ] && grep -q "^TEST RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
